//--- Bender.yml
package:
  name: mul_coproc

sources:
  - files:
      - hdl/coprocPkg.sv
      - hdl/mulIf.sv
      - hdl/bwMultiplier.sv
      - hdl/mulArbiter.sv
      - hdl/macUnit.sv
      - hdl/gainScaler.sv
      - hdl/mulCoproc.sv
  - target: simulation
    files:
      - tb/tbMulCoproc.sv

//--- flist.f
hdl/coprocPkg.sv
hdl/mulIf.sv
hdl/bwMultiplier.sv
hdl/mulArbiter.sv
hdl/macUnit.sv
hdl/gainScaler.sv
hdl/mulCoproc.sv
tb/tbMulCoproc.sv

//--- hdl/bwMultiplier.sv
`timescale 1ns/100ps

// signed baugh-wooley array multiplier, registered output
module bwMultiplier #(
    parameter int MUL_STAGES = 2  // register stages, at least 1
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               inValid,   // operands valid this cycle
    input  coprocPkg::dataT    opA,       // multiplicand
    input  coprocPkg::dataT    opB,       // multiplier
    output logic               outValid,
    output coprocPkg::productT product
);

    localparam int Width = coprocPkg::DATA_WIDTH;

    logic [Width-1:0] pp    [Width];    // partial product bits, row = opB bit
    logic [Width-1:0] carry [Width-1];  // carries per adder row
    logic [Width-2:0] sum   [Width-2];  // sums passed down to next row
    coprocPkg::productT rawProd;        // combinational result

    coprocPkg::productT    prodPipe  [MUL_STAGES];
    logic [MUL_STAGES-1:0] validPipe;

    // one adder cell, {cout, s}; half adder is c = 0
    function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
        return {(a & b) | (a & c) | (b & c), a ^ b ^ c};
    endfunction

    // partial products, nand on sign row and sign column
    for (genvar i = 0; i < Width-1; i++) begin : gPpRow
        for (genvar j = 0; j < Width-1; j++) begin : gPpCol
            assign pp[i][j] = opA[j] & opB[i];
        end
        assign pp[i][Width-1] = ~(opA[Width-1] & opB[i]);  // sign column
    end
    for (genvar k = 0; k < Width-1; k++) begin : gPpSign
        assign pp[Width-1][k] = ~(opB[Width-1] & opA[k]);  // sign row
    end
    assign pp[Width-1][Width-1] = opA[Width-1] & opB[Width-1];  // both signs, plain and

    assign rawProd[0] = pp[0][0];

    // first row adds rows 0 and 1 of pp
    assign {carry[0][0], rawProd[1]} = fa(pp[0][1], pp[1][0], 1'b0);
    for (genvar k = 1; k < Width-1; k++) begin : gRow0
        assign {carry[0][k], sum[0][k-1]} = fa(pp[0][k+1], pp[1][k], carry[0][k-1]);
    end
    // correction 1 at weight Width enters here
    assign {carry[0][Width-1], sum[0][Width-2]} =
        fa(pp[1][Width-1], 1'b1, carry[0][Width-2]);

    // middle rows, each one ripple adder over previous sums
    for (genvar i = 1; i < Width-2; i++) begin : gRowMid
        assign {carry[i][0], rawProd[i+1]} = fa(pp[i+1][0], sum[i-1][0], 1'b0);
        for (genvar k = 1; k < Width-1; k++) begin : gCell
            assign {carry[i][k], sum[i][k-1]} =
                fa(pp[i+1][k], sum[i-1][k], carry[i][k-1]);
        end
        assign {carry[i][Width-1], sum[i][Width-2]} =
            fa(pp[i+1][Width-1], carry[i-1][Width-1], carry[i][Width-2]);
    end

    // last row writes the upper half of the product
    assign {carry[Width-2][0], rawProd[Width-1]} = fa(pp[Width-1][0], sum[Width-3][0], 1'b0);
    for (genvar k = 1; k < Width-1; k++) begin : gRowLast
        assign {carry[Width-2][k], rawProd[k+Width-1]} =
            fa(pp[Width-1][k], sum[Width-3][k], carry[Width-2][k-1]);
    end
    assign {carry[Width-2][Width-1], rawProd[2*Width-2]} =
        fa(pp[Width-1][Width-1], carry[Width-3][Width-1], carry[Width-2][Width-2]);

    // correction 1 at the msb
    assign rawProd[2*Width-1] = ~carry[Width-2][Width-1];

    // product pipeline, data only
    always_ff @(posedge clk) begin
        prodPipe[0] <= rawProd;
        for (int s = 1; s < MUL_STAGES; s++) begin
            prodPipe[s] <= prodPipe[s-1];
        end
    end

    // valid shifts alongside
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= inValid;
            for (int s = 1; s < MUL_STAGES; s++) begin
                validPipe[s] <= validPipe[s-1];
            end
        end
    end

    assign product  = prodPipe[MUL_STAGES-1];
    assign outValid = validPipe[MUL_STAGES-1];

    // latency is fixed at MUL_STAGES, and the array result is the signed product
    aValidLatency: assert property (
        @(posedge clk) disable iff (!rstN)
        inValid |-> ##MUL_STAGES (outValid && product ==
            $past(coprocPkg::productT'(opA) * coprocPkg::productT'(opB), MUL_STAGES))
    );

endmodule

//--- hdl/coprocPkg.sv
// shared widths and types for the multiply coprocessor
package coprocPkg;

    localparam int DATA_WIDTH = 16;  // operand / sample bits
    localparam int ACC_WIDTH  = 40;  // accumulator bits, guard for long dot products
    localparam int GAIN_FRAC  = 12;  // fraction bits of the gain, 1.0 = 4096

    // signed sample or operand
    typedef logic signed [DATA_WIDTH-1:0] dataT;

    // full two's complement product
    typedef logic signed [2*DATA_WIDTH-1:0] productT;

    // running sum in the MAC
    typedef logic signed [ACC_WIDTH-1:0] accT;

    // owner of a multiplier slot
    typedef enum logic {
        clientMac  = 1'b0,
        clientGain = 1'b1
    } clientE;

endpackage

//--- hdl/gainScaler.sv
`timescale 1ns/100ps

// fixed point gain, product rescaled and saturated to sample width
module gainScaler (
    input  logic            clk,
    input  logic            rstN,
    input  logic            gainLoad,
    input  coprocPkg::dataT gainIn,       // GAIN_FRAC fraction bits
    input  logic            sampleValid,
    input  coprocPkg::dataT sampleIn,
    output logic            gainReady,
    output logic            scaledValid,
    output coprocPkg::dataT scaledOut,
    mulIf.client            mulPort
);

    localparam coprocPkg::dataT MaxData = {1'b0, {(coprocPkg::DATA_WIDTH-1){1'b1}}};
    localparam coprocPkg::dataT MinData = {1'b1, {(coprocPkg::DATA_WIDTH-1){1'b0}}};

    coprocPkg::dataT    gainReg;
    coprocPkg::dataT    sampleReg;
    coprocPkg::productT shifted;  // product back to integer scale
    coprocPkg::dataT    satVal;
    logic               reqReg;
    logic               busy;

    assign gainReady = !busy;

    // arithmetic shift keeps the sign, then clamp
    always_comb begin
        shifted = mulPort.product >>> coprocPkg::GAIN_FRAC;
        if (shifted > coprocPkg::productT'(MaxData))      satVal = MaxData;
        else if (shifted < coprocPkg::productT'(MinData)) satVal = MinData;
        else                                              satVal = coprocPkg::dataT'(shifted);
    end

    always_ff @(posedge clk) begin
        if (sampleValid && !busy) sampleReg <= sampleIn;
        if (mulPort.productValid) scaledOut <= satVal;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gainReg     <= '0;
            reqReg      <= 1'b0;
            busy        <= 1'b0;
            scaledValid <= 1'b0;
        end else begin
            scaledValid <= mulPort.productValid;
            if (gainLoad) gainReg <= gainIn;
            if (sampleValid && !busy) begin
                reqReg <= 1'b1;
                busy   <= 1'b1;
            end else if (mulPort.grant) begin
                reqReg <= 1'b0;
            end
            if (mulPort.productValid) busy <= 1'b0;  // ready back with the result
        end
    end

    assign mulPort.req = reqReg;
    assign mulPort.opA = sampleReg;
    assign mulPort.opB = gainReg;

endmodule

//--- hdl/macUnit.sv
`timescale 1ns/100ps

// multiply-accumulate client
module macUnit (
    input  logic            clk,
    input  logic            rstN,
    input  logic            macClear,     // zero the accumulator
    input  logic            sampleValid,
    input  coprocPkg::dataT sampleX,
    input  coprocPkg::dataT weightW,
    output logic            macReady,
    output logic            accValid,     // one pulse per sample
    output coprocPkg::accT  accOut,
    mulIf.client            mulPort
);

    coprocPkg::dataT xReg;  // latched operands
    coprocPkg::dataT wReg;
    logic            reqReg;
    logic            busy;  // sample accepted, result not back yet
    logic            accept;

    assign accept   = sampleValid && !busy;
    assign macReady = !busy;

    // operands only move when a sample is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            xReg <= sampleX;
            wReg <= weightW;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqReg   <= 1'b0;
            busy     <= 1'b0;
            accValid <= 1'b0;
            accOut   <= '0;
        end else begin
            accValid <= 1'b0;
            if (macClear) accOut <= '0;  // only while idle
            if (accept) begin
                reqReg <= 1'b1;
                busy   <= 1'b1;
            end else if (mulPort.grant) begin
                reqReg <= 1'b0;  // one request per sample
            end
            if (mulPort.productValid) begin
                accOut   <= accOut + coprocPkg::accT'(mulPort.product);  // sign extended
                accValid <= 1'b1;
                busy     <= 1'b0;
            end
        end
    end

    assign mulPort.req = reqReg;
    assign mulPort.opA = xReg;
    assign mulPort.opB = wReg;

    // driver must respect ready
    aNoSampleBusy: assert property (
        @(posedge clk) disable iff (!rstN) sampleValid |-> macReady
    );

endmodule

//--- hdl/mulArbiter.sv
`timescale 1ns/100ps

// round-robin share of the multiplier between mac and gain clients
module mulArbiter #(
    parameter int MUL_STAGES = 2  // must match the multiplier depth
) (
    input  logic               clk,
    input  logic               rstN,
    mulIf.server               macPort,
    mulIf.server               gainPort,
    output logic               mulValid,    // to multiplier inValid
    output coprocPkg::dataT    mulA,
    output coprocPkg::dataT    mulB,
    input  logic               mulDone,     // multiplier outValid
    input  coprocPkg::productT mulProduct
);

    coprocPkg::clientE lastGrant;              // winner of the last grant
    coprocPkg::clientE winner;
    coprocPkg::clientE ownerPipe [MUL_STAGES]; // tag per slot in flight

    // pick a winner, tie goes to the one not served last
    always_comb begin
        if (macPort.req && gainPort.req) begin
            winner = (lastGrant == coprocPkg::clientMac) ? coprocPkg::clientGain
                                                         : coprocPkg::clientMac;
        end else if (gainPort.req) begin
            winner = coprocPkg::clientGain;
        end else begin
            winner = coprocPkg::clientMac;  // also the idle default
        end
    end

    assign macPort.grant  = macPort.req  && (winner == coprocPkg::clientMac);
    assign gainPort.grant = gainPort.req && (winner == coprocPkg::clientGain);

    // operand mux into the multiplier
    assign mulValid = macPort.req | gainPort.req;
    assign mulA     = (winner == coprocPkg::clientGain) ? gainPort.opA : macPort.opA;
    assign mulB     = (winner == coprocPkg::clientGain) ? gainPort.opB : macPort.opB;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lastGrant <= coprocPkg::clientGain;  // mac wins the first tie
        end else if (mulValid) begin
            lastGrant <= winner;
        end
    end

    // owner tags track the product pipeline
    always_ff @(posedge clk) begin
        ownerPipe[0] <= winner;
        for (int s = 1; s < MUL_STAGES; s++) begin
            ownerPipe[s] <= ownerPipe[s-1];
        end
    end

    // route the product back to whoever asked
    assign macPort.productValid  = mulDone && (ownerPipe[MUL_STAGES-1] == coprocPkg::clientMac);
    assign gainPort.productValid = mulDone && (ownerPipe[MUL_STAGES-1] == coprocPkg::clientGain);
    assign macPort.product       = mulProduct;
    assign gainPort.product      = mulProduct;

    // each grant comes back to the same client after the multiplier latency
    aMacReturn: assert property (
        @(posedge clk) disable iff (!rstN) macPort.grant |-> ##MUL_STAGES macPort.productValid
    );

    aGainReturn: assert property (
        @(posedge clk) disable iff (!rstN) gainPort.grant |-> ##MUL_STAGES gainPort.productValid
    );

endmodule

//--- hdl/mulCoproc.sv
`timescale 1ns/100ps

// coprocessor top, two clients sharing one multiplier
module mulCoproc #(
    parameter int MUL_STAGES = 2
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            macClear,
    input  logic            macSampleValid,
    input  coprocPkg::dataT macSampleX,
    input  coprocPkg::dataT macWeightW,
    output logic            macReady,
    output logic            macAccValid,
    output coprocPkg::accT  macAccOut,
    input  logic            gainLoad,
    input  coprocPkg::dataT gainIn,
    input  logic            gainSampleValid,
    input  coprocPkg::dataT gainSampleIn,
    output logic            gainReady,
    output logic            gainScaledValid,
    output coprocPkg::dataT gainScaledOut
);

    mulIf macBus ();
    mulIf gainBus ();

    logic               mulValid;    // arbiter to multiplier
    coprocPkg::dataT    mulA;
    coprocPkg::dataT    mulB;
    logic               mulDone;     // multiplier back to arbiter
    coprocPkg::productT mulProduct;

    macUnit macUnit_inst (
        .clk(clk), .rstN(rstN), .macClear(macClear), .sampleValid(macSampleValid),
        .sampleX(macSampleX), .weightW(macWeightW), .macReady(macReady),
        .accValid(macAccValid), .accOut(macAccOut), .mulPort(macBus.client)
    );

    gainScaler gainScaler_inst (
        .clk(clk), .rstN(rstN), .gainLoad(gainLoad), .gainIn(gainIn),
        .sampleValid(gainSampleValid), .sampleIn(gainSampleIn), .gainReady(gainReady),
        .scaledValid(gainScaledValid), .scaledOut(gainScaledOut), .mulPort(gainBus.client)
    );

    mulArbiter #(.MUL_STAGES(MUL_STAGES)) mulArbiter_inst (
        .clk(clk), .rstN(rstN), .macPort(macBus.server), .gainPort(gainBus.server),
        .mulValid(mulValid), .mulA(mulA), .mulB(mulB),
        .mulDone(mulDone), .mulProduct(mulProduct)
    );

    bwMultiplier #(.MUL_STAGES(MUL_STAGES)) bwMultiplier_inst (
        .clk(clk), .rstN(rstN), .inValid(mulValid), .opA(mulA), .opB(mulB),
        .outValid(mulDone), .product(mulProduct)
    );

endmodule

//--- hdl/mulIf.sv
`timescale 1ns/100ps

// one client's path to the shared multiplier
interface mulIf;

    logic                  req;           // level, held until grant
    coprocPkg::dataT       opA;           // multiplicand
    coprocPkg::dataT       opB;           // multiplier
    logic                  grant;         // one-cycle pulse from arbiter
    logic                  productValid;  // one-cycle pulse, product below is ours
    coprocPkg::productT    product;

    // the requesting unit
    modport client (
        output req, opA, opB,
        input  grant, productValid, product
    );

    // the arbiter side
    modport server (
        input  req, opA, opB,
        output grant, productValid, product
    );

endinterface

//--- tb/tbMulCoproc.sv
`timescale 1ns/100ps

// directed testbench for the multiply coprocessor
module tbMulCoproc;

    localparam int MulStages     = 2;
    localparam int TimeoutCycles = 40;  // per wait

    logic            clk;
    logic            rstN;
    logic            macClear;
    logic            macSampleValid;
    coprocPkg::dataT macSampleX;
    coprocPkg::dataT macWeightW;
    logic            macReady;
    logic            macAccValid;
    coprocPkg::accT  macAccOut;
    logic            gainLoad;
    coprocPkg::dataT gainIn;
    logic            gainSampleValid;
    coprocPkg::dataT gainSampleIn;
    logic            gainReady;
    logic            gainScaledValid;
    coprocPkg::dataT gainScaledOut;

    integer          seed = 51311;
    coprocPkg::accT  expAcc;   // running sum model
    coprocPkg::dataT curGain;  // gain the DUT holds now
    coprocPkg::accT  accGot;
    coprocPkg::dataT scaledGot;

    mulCoproc #(.MUL_STAGES(MulStages)) mulCoproc_inst (
        .clk(clk), .rstN(rstN), .macClear(macClear), .macSampleValid(macSampleValid),
        .macSampleX(macSampleX), .macWeightW(macWeightW), .macReady(macReady),
        .macAccValid(macAccValid), .macAccOut(macAccOut), .gainLoad(gainLoad),
        .gainIn(gainIn), .gainSampleValid(gainSampleValid), .gainSampleIn(gainSampleIn),
        .gainReady(gainReady), .gainScaledValid(gainScaledValid), .gainScaledOut(gainScaledOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // x times w, sign extended to accumulator width
    function automatic coprocPkg::accT productModel(input coprocPkg::dataT x,
                                                    input coprocPkg::dataT w);
        return coprocPkg::accT'(longint'(x) * longint'(w));
    endfunction

    // s times g, arithmetic shift by the fraction bits, then clamp
    function automatic coprocPkg::dataT scaleModel(input coprocPkg::dataT s,
                                                   input coprocPkg::dataT g);
        longint p;
        longint hi;
        hi = (longint'(1) <<< (coprocPkg::DATA_WIDTH - 1)) - 1;
        p  = (longint'(s) * longint'(g)) >>> coprocPkg::GAIN_FRAC;
        if (p > hi) return coprocPkg::dataT'(hi);
        if (p < -hi - 1) return coprocPkg::dataT'(-hi - 1);
        return coprocPkg::dataT'(p);
    endfunction

    task automatic checkAcc(input string what, input coprocPkg::accT got,
                            input coprocPkg::accT exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s accOut %0d, expected %0d", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "accumulator mismatch");
        end
    endtask

    task automatic checkScaled(input string what, input coprocPkg::dataT got,
                               input coprocPkg::dataT exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s scaledOut %0d, expected %0d", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "scaled output mismatch");
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "status flag mismatch");
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;  // drive and sample just after the edge
    endtask

    // wait for the wanted result pulses, in any order
    task automatic waitResults(input logic wantMac, input logic wantGain,
                               output coprocPkg::accT accVal, output coprocPkg::dataT scVal);
        int   n;
        logic gotMac;
        logic gotGain;
        n       = 0;
        gotMac  = !wantMac;
        gotGain = !wantGain;
        accVal  = '0;
        scVal   = '0;
        while (!(gotMac && gotGain)) begin
            if (n == TimeoutCycles) begin
                $display("timeout: result pulse missing after %0d cycles", TimeoutCycles);
                $display(">>> FAIL");
                $fatal(1, "timeout");
            end
            tick();
            n++;
            if (wantMac && macAccValid) begin
                gotMac = 1'b1;
                accVal = macAccOut;
            end
            if (wantGain && gainScaledValid) begin
                gotGain = 1'b1;
                scVal   = gainScaledOut;
            end
        end
    endtask

    task automatic sendBoth(input logic toMac, input logic toGain, input coprocPkg::dataT x,
                            input coprocPkg::dataT w, input coprocPkg::dataT s);
        macSampleX      = x;
        macWeightW      = w;
        gainSampleIn    = s;
        macSampleValid  = toMac;
        gainSampleValid = toGain;
        tick();  // accepted on this edge
        macSampleValid  = 1'b0;
        gainSampleValid = 1'b0;
        if (toMac) expAcc = expAcc + productModel(x, w);
    endtask

    task automatic loadGain(input coprocPkg::dataT g);
        gainIn   = g;
        gainLoad = 1'b1;
        tick();
        gainLoad = 1'b0;
        curGain  = g;
    endtask

    task automatic clearAcc();
        macClear = 1'b1;
        tick();
        macClear = 1'b0;
        expAcc   = '0;
    endtask

    task automatic scaleOne(input coprocPkg::dataT s);
        sendBoth(1'b0, 1'b1, '0, '0, s);
        waitResults(1'b0, 1'b1, accGot, scaledGot);
        checkScaled("gain scale", scaledGot, scaleModel(s, curGain));
    endtask

    task automatic testReset();
        checkFlag("macReady", macReady, 1'b1);
        checkFlag("gainReady", gainReady, 1'b1);
        checkFlag("macAccValid", macAccValid, 1'b0);
        checkFlag("gainScaledValid", gainScaledValid, 1'b0);
        checkAcc("reset", macAccOut, '0);
    endtask

    task automatic testGain();
        coprocPkg::dataT gains [4];
        coprocPkg::dataT corners [5];
        gains   = '{16'sd4096, -16'sd4096, 16'sd2048, 16'sd20000};  // 1.0 -1.0 0.5 ~4.9
        corners = '{16'sd0, 16'sd1, -16'sd1, 16'sd32767, -16'sd32768};
        foreach (gains[g]) begin
            loadGain(gains[g]);
            foreach (corners[c]) scaleOne(corners[c]);
            repeat (4) scaleOne(coprocPkg::dataT'($random(seed)));
        end
    endtask

    task automatic testDotProduct();
        clearAcc();
        repeat (16) begin
            sendBoth(1'b1, 1'b0, coprocPkg::dataT'($random(seed)),
                     coprocPkg::dataT'($random(seed)), '0);
            waitResults(1'b1, 1'b0, accGot, scaledGot);
            checkAcc("dot product", accGot, expAcc);
        end
    endtask

    task automatic testContention();
        coprocPkg::dataT s;
        repeat (8) begin
            loadGain(coprocPkg::dataT'($random(seed)));
            s = coprocPkg::dataT'($random(seed));
            sendBoth(1'b1, 1'b1, coprocPkg::dataT'($random(seed)),
                     coprocPkg::dataT'($random(seed)), s);  // same edge, both clients
            waitResults(1'b1, 1'b1, accGot, scaledGot);
            checkAcc("contention mac", accGot, expAcc);
            checkScaled("contention gain", scaledGot, scaleModel(s, curGain));
        end
    endtask

    task automatic testClearReuse();
        checkFlag("sum nonzero before clear", macAccOut != '0, 1'b1);
        clearAcc();
        checkAcc("after clear", macAccOut, '0);
        sendBoth(1'b1, 1'b0, -16'sd1234, 16'sd5678, '0);
        waitResults(1'b1, 1'b0, accGot, scaledGot);
        checkAcc("first after clear", accGot, productModel(-16'sd1234, 16'sd5678));
    endtask

    task automatic testBackPressure();
        sendBoth(1'b1, 1'b0, 16'sd300, -16'sd7, '0);
        checkFlag("macReady while busy", macReady, 1'b0);
        waitResults(1'b1, 1'b0, accGot, scaledGot);
        checkFlag("macReady with result", macReady, 1'b1);
        checkAcc("back-pressure mac", accGot, expAcc);
        sendBoth(1'b0, 1'b1, '0, '0, 16'sd1000);
        checkFlag("gainReady while busy", gainReady, 1'b0);
        waitResults(1'b0, 1'b1, accGot, scaledGot);
        checkFlag("gainReady with result", gainReady, 1'b1);
        checkScaled("back-pressure gain", scaledGot, scaleModel(16'sd1000, curGain));
    endtask

    initial begin
        rstN            = 1'b0;
        macClear        = 1'b0;
        macSampleValid  = 1'b0;
        macSampleX      = '0;
        macWeightW      = '0;
        gainLoad        = 1'b0;
        gainIn          = '0;
        gainSampleValid = 1'b0;
        gainSampleIn    = '0;
        expAcc          = '0;
        curGain         = '0;  // gain register resets to zero
        repeat (10) @(posedge clk);
        #2 rstN = 1'b1;
        tick();
        testReset();
        testGain();
        testDotProduct();
        testContention();
        testClearReuse();
        testBackPressure();
        $display(">>> PASS");
        $finish;
    end

endmodule
